// ==== tb.f ====
logic/mem_map_pkg.sv
logic/trace_pkg.sv
logic/region_decode.sv
logic/text_write_seq.sv
logic/loader_ram.sv
logic/slow_store.sv
logic/miss_trace.sv
logic/cpu_mem_port.sv
verif/tb_cpu_mem_port.sv

// ==== verif/tb_cpu_mem_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_mem_port
    import mem_map_pkg::*, trace_pkg::*;
();

    localparam int store_lat  = 3;
    localparam int text_hold  = 7;
    localparam int wait_limit = 64;

    logic         cache_stall;
    logic         rst;
    word_addr_t   instr_addr;
    word_addr_t   dmem_addr;
    logic         dmem_read;
    logic         dmem_write;
    byte_en_t     dmem_byte_en;
    word_t        data_from_reg;
    loader_addr_t loader_addr;
    text_addr_t   text_peek_addr;
    word_t        instr_data;
    word_t        dmem_data;
    logic         mem_stall;
    word_t        loader_data;
    logic [7:0]   text_peek_char;

    // reference state
    word_t      store_model [0:255];
    word_t      loader_model [0:8191];
    trace_rec_t trace_model [0:63];
    trace_ptr_t m_start;
    trace_ptr_t m_end;
    miss_cnt_t  m_miss;

    // pending checks for the compare process
    string chk_name [$];
    word_t chk_exp [$];
    word_t chk_act [$];
    int    posted;
    int    compared;
    int    value_errors;
    int    timeouts;

    cpu_mem_port #(
        .STORE_LATENCY (store_lat),
        .TEXT_HOLD     (text_hold)
    ) uut (
        .cache_stall    (cache_stall),
        .rst            (rst),
        .instr_addr     (instr_addr),
        .dmem_addr      (dmem_addr),
        .dmem_read      (dmem_read),
        .dmem_write     (dmem_write),
        .dmem_byte_en   (dmem_byte_en),
        .data_from_reg  (data_from_reg),
        .loader_addr    (loader_addr),
        .text_peek_addr (text_peek_addr),
        .instr_data     (instr_data),
        .dmem_data      (dmem_data),
        .mem_stall      (mem_stall),
        .loader_data    (loader_data),
        .text_peek_char (text_peek_char)
    );

    initial begin
        cache_stall = 1'b0;
        forever #2 cache_stall = ~cache_stall;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference functions
    ////////////////////////////////////////////////////////////////////////////

    // enable msb is lane 0 with bits 7..0
    function automatic word_t merge_bytes(word_t old, word_t wdata, byte_en_t en);
        word_t res;
        res = old;
        if (en[3]) res[7:0] = wdata[7:0];
        if (en[2]) res[15:8] = wdata[15:8];
        if (en[1]) res[23:16] = wdata[23:16];
        if (en[0]) res[31:24] = wdata[31:24];
        return res;
    endfunction

    function automatic logic [1:0] lane_of(byte_en_t en);
        case (en)
            4'b1000: return 2'd0;
            4'b0100: return 2'd1;
            4'b0010: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    function automatic text_addr_t text_byte_addr(word_addr_t addr, byte_en_t en);
        return {addr[9:0], lane_of(en)};
    endfunction

    function automatic logic [7:0] lane_char(word_t data, byte_en_t en);
        return data[8*lane_of(en) +: 8];
    endfunction

    function automatic trace_rec_t build_record(word_addr_t addr, word_t data, logic wr,
                                                miss_cnt_t miss, int step);
        word_t w2;
        w2 = {wr, 24'd0, miss};
        return {word_t'(step), w2, data, {2'b00, addr}};
    endfunction

    function automatic word_addr_t rand_store_addr();
        logic [3:0] nib;
        nib = 4'($urandom % 12);
        return {nib, 26'($urandom)};
    endfunction

    // one stall episode gives STORE_LATENCY records with a rising step index
    task automatic trace_episode(word_addr_t addr, word_t data, logic wr);
        m_start = m_end;
        m_miss  = m_miss + 1'b1;
        for (int k = 0; k < store_lat; k++) begin
            trace_model[m_end] = build_record(addr, data, wr, m_miss, k);
            m_end = m_end + 1'b1;
        end
    endtask

    task automatic queue_check(string name, word_t exp, word_t act);
        chk_name.push_back(name);
        chk_exp.push_back(exp);
        chk_act.push_back(act);
        posted++;
    endtask

    // drive one access, hold it while mem_stall is high, then drop it
    task automatic do_access(input string name, input word_addr_t addr, input logic rd,
                             input logic wr, input byte_en_t en, input word_t data,
                             output int cycles, output word_t rdata);
        int n;
        @(negedge cache_stall);
        dmem_addr     = addr;
        dmem_read     = rd;
        dmem_write    = wr;
        dmem_byte_en  = en;
        data_from_reg = data;
        #1;
        n = 0;
        while (mem_stall && n < wait_limit) begin
            n++;
            @(negedge cache_stall);
        end
        if (mem_stall) begin
            timeouts++;
            $display("timeout: mem_stall never dropped during %s", name);
        end
        // no stall means one edge for registered read data
        if (n == 0) begin
            @(negedge cache_stall);
        end
        rdata      = dmem_data;
        cycles     = n;
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        if (addr[29:26] < code_text) begin
            trace_episode(addr, data, wr);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare process
    ////////////////////////////////////////////////////////////////////////////

    initial begin : compare_proc
        string nm;
        word_t e;
        word_t a;
        forever begin
            @(posedge cache_stall);
            while (compared != posted) begin
                nm = chk_name.pop_front();
                e  = chk_exp.pop_front();
                a  = chk_act.pop_front();
                compared++;
                assert (a === e) else begin
                    value_errors++;
                    $display("ERR %s expected %h actual %h", nm, e, a);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        word_addr_t   s_addr [8];
        word_addr_t   t_addr [4];
        text_addr_t   t_byte [4];
        logic [7:0]   t_char [4];
        loader_addr_t l_addr [6];
        byte_en_t     en_pick [5];
        byte_en_t     en;
        word_t        wd;
        word_t        rd;
        word_addr_t   a;
        trace_ptr_t   p;
        int           cyc;
        int           n;

        void'($urandom(32'hd752));
        en_pick = '{4'b1000, 4'b0100, 4'b0010, 4'b0001, 4'b1111};
        posted = 0;
        compared = 0;
        value_errors = 0;
        timeouts = 0;
        m_start = '0;
        m_end = '0;
        m_miss = '0;
        rst = 1'b0;
        instr_addr = '0;
        dmem_addr = '0;
        dmem_read = 1'b0;
        dmem_write = 1'b0;
        dmem_byte_en = 4'b1111;
        data_from_reg = '0;
        loader_addr = '0;
        text_peek_addr = '0;
        repeat (5) @(posedge cache_stall);
        @(negedge cache_stall);
        rst = 1'b1;
        @(negedge cache_stall);
        queue_check("reset_stall", 0, mem_stall);

        // full-word store writes first so no byte stays unknown
        for (int i = 0; i < 8; i++) begin
            s_addr[i] = rand_store_addr();
            wd = $urandom;
            do_access("store_write", s_addr[i], 1'b0, 1'b1, 4'b1111, wd, cyc, rd);
            store_model[s_addr[i][7:0]] = wd;
            queue_check("store_write_stall", store_lat, cyc);
        end
        for (int i = 0; i < 8; i++) begin
            wd = $urandom;
            en = en_pick[$urandom % 5];
            do_access("store_merge", s_addr[i], 1'b0, 1'b1, en, wd, cyc, rd);
            store_model[s_addr[i][7:0]] = merge_bytes(store_model[s_addr[i][7:0]], wd, en);
            queue_check("store_merge_stall", store_lat, cyc);
        end
        for (int i = 0; i < 8; i++) begin
            do_access("store_read", s_addr[i], 1'b1, 1'b0, 4'b1111, '0, cyc, rd);
            queue_check("store_read", store_model[s_addr[i][7:0]], rd);
            queue_check("store_read_stall", store_lat, cyc);
        end

        // one text write per lane
        for (int i = 0; i < 4; i++) begin
            t_addr[i] = {4'hc, 26'($urandom)};
            en = 4'b1000 >> i;
            wd = $urandom;
            do_access("text_write", t_addr[i], 1'b0, 1'b1, en, wd, cyc, rd);
            t_byte[i] = text_byte_addr(t_addr[i], en);
            t_char[i] = lane_char(wd, en);
            queue_check("text_stall", text_hold, cyc);
        end
        for (int i = 0; i < 4; i++) begin
            @(negedge cache_stall);
            text_peek_addr = t_byte[i];
            @(negedge cache_stall);
            queue_check("text_peek", {24'd0, t_char[i]}, {24'd0, text_peek_char});
        end

        // trap holds as long as the request does
        @(negedge cache_stall);
        dmem_addr = {4'hd, trap_tag, 18'($urandom)};
        dmem_read = 1'b1;
        repeat (5) begin
            @(negedge cache_stall);
            queue_check("trap_held", 1, mem_stall);
        end
        dmem_read = 1'b0;
        @(negedge cache_stall);
        queue_check("trap_released", 0, mem_stall);
        do_access("debug_no_trap", {4'hd, 8'h5a, 18'($urandom)}, 1'b1, 1'b0,
                  4'b1111, '0, cyc, rd);
        queue_check("debug_no_trap_stall", 0, cyc);

        // loader through the data port, then the instruction and external ports
        for (int i = 0; i < 6; i++) begin
            l_addr[i] = 13'($urandom);
            wd = $urandom;
            do_access("loader_write", {4'hf, 13'd0, l_addr[i]}, 1'b0, 1'b1,
                      4'b1111, wd, cyc, rd);
            loader_model[l_addr[i]] = wd;
            queue_check("loader_write_stall", 0, cyc);
        end
        for (int i = 0; i < 6; i++) begin
            do_access("loader_read", {4'hf, 13'd0, l_addr[i]}, 1'b1, 1'b0,
                      4'b1111, '0, cyc, rd);
            queue_check("loader_read", loader_model[l_addr[i]], rd);
        end
        for (int i = 0; i < 6; i++) begin
            @(negedge cache_stall);
            instr_addr = {4'hf, 13'd0, l_addr[i]};
            @(negedge cache_stall);
            queue_check("loader_fetch", loader_model[l_addr[i]], instr_data);
        end
        // fetches outside region f come from the store
        for (int i = 0; i < 8; i++) begin
            @(negedge cache_stall);
            instr_addr = s_addr[i];
            @(negedge cache_stall);
            queue_check("store_fetch", store_model[s_addr[i][7:0]], instr_data);
        end
        @(negedge cache_stall);
        instr_addr = '0;
        dmem_addr = '0;
        for (int i = 0; i < 6; i++) begin
            @(negedge cache_stall);
            loader_addr = l_addr[i];
            @(negedge cache_stall);
            queue_check("loader_external", loader_model[l_addr[i]], loader_data);
        end

        // keyboard aliasing a stored word must not touch the store
        a = {4'he, 18'd0, s_addr[0][7:0]};
        do_access("kbd_write", a, 1'b0, 1'b1, 4'b1111, $urandom, cyc, rd);
        queue_check("kbd_write_stall", 0, cyc);
        do_access("kbd_read", a, 1'b1, 1'b0, 4'b1111, '0, cyc, rd);
        queue_check("kbd_read", 0, rd);
        queue_check("kbd_read_stall", 0, cyc);
        do_access("kbd_store_kept", s_addr[0], 1'b1, 1'b0, 4'b1111, '0, cyc, rd);
        queue_check("kbd_store_kept", store_model[s_addr[0][7:0]], rd);

        // trace of the last episode
        wd = $urandom;
        do_access("trace_store_write", s_addr[3], 1'b0, 1'b1, 4'b1111, wd, cyc, rd);
        store_model[s_addr[3][7:0]] = wd;
        do_access("trace_store_read", s_addr[5], 1'b1, 1'b0, 4'b1111, $urandom, cyc, rd);
        queue_check("trace_store_read", store_model[s_addr[5][7:0]], rd);
        do_access("trace_start", {4'hd, dbg_start_offset}, 1'b1, 1'b0, 4'b1111, '0, cyc, rd);
        queue_check("trace_start", {26'd0, m_start}, rd);
        do_access("trace_end", {4'hd, dbg_end_offset}, 1'b1, 1'b0, 4'b1111, '0, cyc, rd);
        queue_check("trace_end", {26'd0, m_end}, rd);
        for (int k = 0; k < store_lat; k++) begin
            p = m_start + trace_ptr_t'(k);
            for (int w = 0; w < 4; w++) begin
                a = {4'hd, 18'd0, p, 2'(w)};
                do_access("trace_record", a, 1'b1, 1'b0, 4'b1111, '0, cyc, rd);
                queue_check("trace_record", trace_model[p][32*w +: 32], rd);
            end
        end

        // let the compare process catch up
        n = 0;
        while (posted != compared && n < wait_limit) begin
            @(negedge cache_stall);
            n++;
        end
        if (posted != compared) begin
            timeouts++;
            $display("timeout: compare process did not finish the pending checks");
        end

        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/cpu_mem_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_mem_port
    import mem_map_pkg::*;
#(
    parameter int STORE_LATENCY = 3,
    parameter int TEXT_HOLD     = 7
) (
    input  wire logic         cache_stall,
    input  wire logic         rst,
    input  wire word_addr_t   instr_addr,
    input  wire word_addr_t   dmem_addr,
    input  wire logic         dmem_read,
    input  wire logic         dmem_write,
    input  wire byte_en_t     dmem_byte_en,
    input  wire word_t        data_from_reg,
    input  wire loader_addr_t loader_addr,
    input  wire text_addr_t   text_peek_addr,
    output word_t             instr_data,
    output word_t             dmem_data,
    output logic              mem_stall,
    output word_t             loader_data,
    output logic [7:0]        text_peek_char
);

    region_t      region;
    logic         store_read;
    logic         store_write;
    logic         text_write;
    logic         trap_stall;
    logic         loader_write;
    logic         loader_data_sel;
    logic         instr_from_loader;
    logic         instr_from_loader_q;
    text_addr_t   text_addr;
    logic [7:0]   text_char;
    logic         text_stall;
    logic         store_stall;
    word_t        store_rdata;
    word_t        store_instr;
    word_t        loader_dout_a;
    word_t        loader_dout_b;
    word_t        dbg_data;
    loader_addr_t loader_addr_a;

    region_decode u_decode (
        .dmem_addr         (dmem_addr),
        .dmem_read         (dmem_read),
        .dmem_write        (dmem_write),
        .dmem_byte_en      (dmem_byte_en),
        .data_from_reg     (data_from_reg),
        .instr_addr        (instr_addr),
        .region            (region),
        .store_read        (store_read),
        .store_write       (store_write),
        .text_write        (text_write),
        .trap_stall        (trap_stall),
        .loader_write      (loader_write),
        .loader_data_sel   (loader_data_sel),
        .instr_from_loader (instr_from_loader),
        .text_addr         (text_addr),
        .text_char         (text_char)
    );

    text_write_seq #(
        .TEXT_HOLD (TEXT_HOLD)
    ) u_text (
        .cache_stall (cache_stall),
        .rst         (rst),
        .text_write  (text_write),
        .text_addr   (text_addr),
        .text_char   (text_char),
        .peek_addr   (text_peek_addr),
        .text_stall  (text_stall),
        .peek_char   (text_peek_char)
    );

    // data port owns port a while it is in the loader region
    assign loader_addr_a = loader_data_sel ? dmem_addr[12:0] : loader_addr;

    loader_ram u_loader (
        .cache_stall (cache_stall),
        .addr_a      (loader_addr_a),
        .din_a       (data_from_reg),
        .we_a        (loader_write),
        .addr_b      (instr_addr[12:0]),
        .dout_a      (loader_dout_a),
        .dout_b      (loader_dout_b)
    );

    slow_store #(
        .STORE_LATENCY (STORE_LATENCY)
    ) u_store (
        .cache_stall (cache_stall),
        .rst         (rst),
        .store_read  (store_read),
        .store_write (store_write),
        .addr        (dmem_addr),
        .byte_en     (dmem_byte_en),
        .wdata       (data_from_reg),
        .instr_addr  (instr_addr),
        .store_stall (store_stall),
        .rdata       (store_rdata),
        .instr_rdata (store_instr)
    );

    miss_trace u_trace (
        .cache_stall   (cache_stall),
        .rst           (rst),
        .store_stall   (store_stall),
        .dmem_addr     (dmem_addr),
        .data_from_reg (data_from_reg),
        .dmem_write    (dmem_write),
        .dbg_data      (dbg_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // read data and stall
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (region)
            reg_store:  dmem_data = store_rdata;
            reg_loader: dmem_data = loader_dout_a;
            reg_debug:  dmem_data = dbg_data;
            default:    dmem_data = '0;
        endcase
    end

    // loader port b answers one cycle late
    always_ff @(posedge cache_stall) begin
        if (!rst) begin
            instr_from_loader_q <= 1'b0;
        end else begin
            instr_from_loader_q <= instr_from_loader;
        end
    end

    assign instr_data  = instr_from_loader_q ? loader_dout_b : store_instr;
    assign loader_data = loader_dout_a;
    assign mem_stall   = store_stall | text_stall | trap_stall;

endmodule

`default_nettype wire

// ==== logic/miss_trace.sv ====
`timescale 1ns/100ps
`default_nettype none

module miss_trace
    import mem_map_pkg::*, trace_pkg::*;
(
    input  wire logic       cache_stall,
    input  wire logic       rst,
    input  wire logic       store_stall,
    input  wire word_addr_t dmem_addr,
    input  wire word_t      data_from_reg,
    input  wire logic       dmem_write,
    output word_t           dbg_data
);

    trace_rec_t queue [trace_depth];
    trace_ptr_t start_ptr;
    trace_ptr_t end_ptr;
    miss_cnt_t  miss_count;
    miss_cnt_t  miss_next;
    word_t      step_idx;
    word_t      step_now;
    logic       in_episode;
    trace_rec_t rec;
    trace_rec_t entry;

    // first stall cycle opens a new episode
    assign miss_next = in_episode ? miss_count : miss_count + 1'b1;
    assign step_now  = in_episode ? step_idx : '0;

    assign rec = {step_now,
                  dmem_write, 24'd0, miss_next,
                  data_from_reg,
                  2'b00, dmem_addr};

    always_ff @(posedge cache_stall) begin
        if (!rst) begin
            start_ptr  <= '0;
            end_ptr    <= '0;
            miss_count <= '0;
            step_idx   <= '0;
            in_episode <= 1'b0;
        end else if (store_stall) begin
            if (!in_episode) begin
                start_ptr <= end_ptr;
            end
            in_episode <= 1'b1;
            miss_count <= miss_next;
            step_idx   <= step_now + 1'b1;
            end_ptr    <= end_ptr + 1'b1;
        end else begin
            in_episode <= 1'b0;
        end
    end

    // queue wraps and overwrites the oldest records
    always_ff @(posedge cache_stall) begin
        if (store_stall) begin
            queue[end_ptr] <= rec;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // debug readout
    ////////////////////////////////////////////////////////////////////////////

    assign entry = queue[dmem_addr[7:2]];

    always_comb begin
        if (dmem_addr[25:0] == dbg_start_offset) begin
            dbg_data = {26'd0, start_ptr};
        end else if (dmem_addr[25:0] == dbg_end_offset) begin
            dbg_data = {26'd0, end_ptr};
        end else begin
            dbg_data = entry[{dmem_addr[1:0], 5'd0} +: 32];
        end
    end

endmodule

`default_nettype wire

// ==== logic/slow_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module slow_store
    import mem_map_pkg::*;
#(
    parameter int STORE_LATENCY = 3
) (
    input  wire logic       cache_stall,
    input  wire logic       rst,
    input  wire logic       store_read,
    input  wire logic       store_write,
    input  wire word_addr_t addr,
    input  wire byte_en_t   byte_en,
    input  wire word_t      wdata,
    input  wire word_addr_t instr_addr,
    output logic            store_stall,
    output word_t           rdata,
    output word_t           instr_rdata
);

    typedef enum logic [1:0] {IDLE, BUSY, DONE} store_state_t;

    localparam int cnt_w = $clog2(STORE_LATENCY + 1);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(STORE_LATENCY - 1);

    store_state_t     state;
    logic [cnt_w-1:0] lat_cnt;
    logic             req;
    logic             busy_edge;
    logic             enter_done;
    logic [7:0]       idx;
    word_t            merged;
    word_t            mem [0:255];

    assign req = store_read | store_write;
    assign idx = addr[7:0];

    // an edge that counts toward the latency
    assign busy_edge  = (state == BUSY) || ((state == IDLE) && req);
    assign enter_done = busy_edge && (lat_cnt == last_cnt);

    // combinational, so the stall shows in the request cycle itself
    assign store_stall = busy_edge;

    always_ff @(posedge cache_stall) begin
        if (!rst) begin
            state   <= IDLE;
            lat_cnt <= '0;
        end else if (enter_done) begin
            state <= DONE;
        end else if (busy_edge) begin
            state   <= BUSY;
            lat_cnt <= lat_cnt + 1'b1;
        end else if (state == DONE) begin
            state   <= IDLE;
            lat_cnt <= '0;
        end
    end

    // enable msb covers bits 7..0, same lane order as the text path
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = byte_en[3-i] ? wdata[8*i +: 8] : mem[idx][8*i +: 8];
        end
    end

    always_ff @(posedge cache_stall) begin
        if (enter_done) begin
            rdata <= mem[idx];
            if (store_write) begin
                mem[idx] <= merged;
            end
        end
    end

    // instruction side never waits
    assign instr_rdata = mem[instr_addr[7:0]];

    // decoder must not steer both levels here at once
    a_rw_exclusive: assert property (
        @(posedge cache_stall) disable iff (!rst)
        !(store_read && store_write)
    );

endmodule

`default_nettype wire

// ==== logic/loader_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module loader_ram
    import mem_map_pkg::*;
(
    input  wire logic         cache_stall,
    input  wire loader_addr_t addr_a,
    input  wire word_t        din_a,
    input  wire logic         we_a,
    input  wire loader_addr_t addr_b,
    output word_t             dout_a,
    output word_t             dout_b
);

    word_t mem [0:8191];

    ////////////////////////////////////////////////////////////////////////////
    // port a, data side and external loader access
    ////////////////////////////////////////////////////////////////////////////

    // read returns the old word on a write cycle
    always_ff @(posedge cache_stall) begin
        dout_a <= mem[addr_a];
        if (we_a) begin
            mem[addr_a] <= din_a;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // port b, instruction fetch
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge cache_stall) begin
        dout_b <= mem[addr_b];
    end

endmodule

`default_nettype wire

// ==== logic/text_write_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module text_write_seq
    import mem_map_pkg::*;
#(
    parameter int TEXT_HOLD = 7
) (
    input  wire logic       cache_stall,
    input  wire logic       rst,
    input  wire logic       text_write,
    input  wire text_addr_t text_addr,
    input  wire logic [7:0] text_char,
    input  wire text_addr_t peek_addr,
    output logic            text_stall,
    output logic [7:0]      peek_char
);

    localparam int cnt_w = $clog2(TEXT_HOLD + 1);
    localparam logic [cnt_w-1:0] hold_last = cnt_w'(TEXT_HOLD);

    logic [cnt_w-1:0] hold_cnt;
    logic [7:0]       text_mem [0:4095];

    // stall at once, release when the counter tops out
    assign text_stall = text_write && (hold_cnt != hold_last);

    // counter parks at hold_last until the write request goes away
    always_ff @(posedge cache_stall) begin
        if (!rst) begin
            hold_cnt <= '0;
        end else if (!text_write) begin
            hold_cnt <= '0;
        end else if (hold_cnt != hold_last) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    // byte lands on the first edge of the episode only
    always_ff @(posedge cache_stall) begin
        if (text_write && (hold_cnt == '0)) begin
            text_mem[text_addr] <= text_char;
        end
    end

    assign peek_char = text_mem[peek_addr];

    // a held text write must let the pipeline go after TEXT_HOLD cycles
    a_text_stall_bounded: assert property (
        @(posedge cache_stall) disable iff (!rst)
        text_stall [*TEXT_HOLD] |=> !text_stall
    );

endmodule

`default_nettype wire

// ==== logic/region_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module region_decode
    import mem_map_pkg::*;
(
    input  wire word_addr_t dmem_addr,
    input  wire logic       dmem_read,
    input  wire logic       dmem_write,
    input  wire byte_en_t   dmem_byte_en,
    input  wire word_t      data_from_reg,
    input  wire word_addr_t instr_addr,
    output region_t         region,
    output logic            store_read,
    output logic            store_write,
    output logic            text_write,
    output logic            trap_stall,
    output logic            loader_write,
    output logic            loader_data_sel,
    output logic            instr_from_loader,
    output text_addr_t      text_addr,
    output logic [7:0]      text_char
);

    logic       access;
    logic [1:0] lane;

    assign access = dmem_read | dmem_write;

    always_comb begin
        case (dmem_addr[29:26])
            code_text:   region = reg_text;
            code_debug:  region = reg_debug;
            code_kbd:    region = reg_kbd;
            code_loader: region = reg_loader;
            default:     region = reg_store;
        endcase
    end

    // one target at most sees the request
    // keyboard and debug reads go nowhere
    assign store_read      = (region == reg_store) & dmem_read;
    assign store_write     = (region == reg_store) & dmem_write;
    assign text_write      = (region == reg_text) & dmem_write;
    assign loader_write    = (region == reg_loader) & dmem_write;
    assign loader_data_sel = (region == reg_loader);

    // level only, held as long as the pipeline holds the access
    assign trap_stall = (region == reg_debug) && (dmem_addr[25:18] == trap_tag) && access;

    assign instr_from_loader = (instr_addr[29:26] == code_loader);

    // byte lane for text writes, enable msb is lane 0
    always_comb begin
        case (dmem_byte_en)
            4'b1000: begin
                lane      = 2'd0;
                text_char = data_from_reg[7:0];
            end
            4'b0100: begin
                lane      = 2'd1;
                text_char = data_from_reg[15:8];
            end
            4'b0010: begin
                lane      = 2'd2;
                text_char = data_from_reg[23:16];
            end
            default: begin
                lane      = 2'd3;
                text_char = data_from_reg[31:24];
            end
        endcase
    end

    assign text_addr = {dmem_addr[9:0], lane};

endmodule

`default_nettype wire

// ==== logic/trace_pkg.sv ====
`default_nettype none

package trace_pkg;

    // four words, word 0 in the low bits
    typedef logic [127:0] trace_rec_t;

    // addr bits 7..2 pick the entry, so 64 deep
    typedef logic [5:0] trace_ptr_t;
    localparam int trace_depth = 64;

    // stall episodes seen since reset
    typedef logic [6:0] miss_cnt_t;

endpackage

`default_nettype wire

// ==== logic/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths that carry a meaning
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [29:0] word_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;

    // byte address into the 4 KB text memory
    typedef logic [11:0] text_addr_t;
    // word address into the 8K word loader RAM
    typedef logic [12:0] loader_addr_t;

    // target of one data access
    typedef enum logic [2:0] {
        reg_store,
        reg_text,
        reg_debug,
        reg_kbd,
        reg_loader
    } region_t;

    // top nibble of the word address
    localparam logic [3:0] code_text   = 4'hc;
    localparam logic [3:0] code_debug  = 4'hd;
    localparam logic [3:0] code_kbd    = 4'he;
    localparam logic [3:0] code_loader = 4'hf;

    // debug region, bits 25..18 pick the trap
    localparam logic [7:0] trap_tag = 8'hdd;

    // debug region, bits 25..0 for the queue pointers
    localparam logic [25:0] dbg_start_offset = 26'h3000001;
    localparam logic [25:0] dbg_end_offset   = 26'h3000002;

endpackage

`default_nettype wire
